// File: Makefile
VERILATOR ?= verilator
TOP       ?= snoopTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
PASSTEXT  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | awk -v pass="$(PASSTEXT)" \
		'{ print } index($$0, pass) { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)

// File: design/busSampler.sv
`timescale 1ns/10ps
`include "snoopCfg.svh"

module busSampler (
  input  logic                     clkin,
  input  logic                     reset,
  input  logic [`SNOOP_ADDR_W-1:0] snesAddr,
  input  logic [`SNOOP_PA_W-1:0]   snesPa,
  input  logic [`SNOOP_DATA_W-1:0] snesDataIn,
  input  logic                     rdEnd,
  input  logic                     wrEnd,
  input  logic                     pardEnd,
  input  logic                     pawrEnd,
  output logic [`SNOOP_ADDR_W-1:0] sAddr,
  output logic [`SNOOP_PA_W-1:0]   sPa,
  output logic [`SNOOP_DATA_W-1:0] sData,
  output logic                     sRd,
  output logic                     sWr,
  output logic                     sPard,
  output logic                     sPawr
);

  // end-of-access pulses
  always_ff @(posedge clkin) begin
    if (reset) begin
      sRd   <= 1'b0;
      sWr   <= 1'b0;
      sPard <= 1'b0;
      sPawr <= 1'b0;
    end else begin
      sRd   <= rdEnd;
      sWr   <= wrEnd;
      sPard <= pardEnd;
      sPawr <= pawrEnd;
    end
  end

  // addresses and data line up with the strobes above
  always_ff @(posedge clkin) begin
    sAddr <= snesAddr;
    sPa   <= snesPa;
    sData <= snesDataIn;
  end

endmodule

// File: design/cgramOamTracker.sv
`timescale 1ns/10ps
`include "snoopCfg.svh"

module cgramOamTracker (
  input  logic                     clkin,
  input  logic                     reset,
  input  logic [`SNOOP_PA_W-1:0]   sPa,
  input  logic [`SNOOP_DATA_W-1:0] sData,
  input  logic                     sPard,
  input  logic                     sPawr,
  output logic                     cgramHit,
  output logic [8:0]               cgramOffset,
  output logic                     oamHit,
  output logic [9:0]               oamOffset
);

  logic [8:0] cgAddr;
  logic [9:0] oamAddr;

  // ------------------------------------------------------------
  // palette address, counted in bytes
  // ------------------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      cgAddr <= '0;
    end else if (sPawr && sPa == snesBusPkg::cgAdd) begin
      cgAddr <= {sData, 1'b0};
    end else if ((sPawr && sPa == snesBusPkg::cgData) ||
                 (sPard && sPa == snesBusPkg::rdCgram)) begin
      cgAddr <= cgAddr + 9'd1;
    end
  end

  // ------------------------------------------------------------
  // sprite table address
  // ------------------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      oamAddr <= '0;
    end else if (sPawr && sPa == snesBusPkg::oamAddL) begin
      oamAddr <= {oamAddr[9], sData, 1'b0};
    end else if (sPawr && sPa == snesBusPkg::oamAddH) begin
      oamAddr <= {sData[0], oamAddr[8:1], 1'b0};
    end else if ((sPawr && sPa == snesBusPkg::oamData) ||
                 (sPard && sPa == snesBusPkg::rdOam)) begin
      oamAddr <= oamAddr + 10'd1;
    end
  end

  assign cgramHit    = sPawr && (sPa == snesBusPkg::cgData);
  assign cgramOffset = cgAddr;
  assign oamHit      = sPawr && (sPa == snesBusPkg::oamData);
  // high table is only 32 bytes, so it folds
  assign oamOffset   = oamAddr[9] ? (oamAddr & 10'h21F) : oamAddr;

endmodule

// File: design/shadowMapPkg.sv
`include "snoopCfg.svh"

package shadowMapPkg;

  // ------------------------------------------------------------
  // shadow memory regions
  // ------------------------------------------------------------

  // 128 KiB of work ram
  localparam logic [`SNOOP_SHADOW_W-1:0] wramBase  = 24'hF50000;

  // 64 KiB of video ram
  localparam logic [`SNOOP_SHADOW_W-1:0] vramBase  = 24'hF70000;

  // 512 bytes of palette, then the sprite table
  localparam logic [`SNOOP_SHADOW_W-1:0] cgramBase = 24'hF90000;
  localparam logic [`SNOOP_SHADOW_W-1:0] oamBase   = 24'hF90200;

endpackage

// File: design/snesBusPkg.sv
`include "snoopCfg.svh"

package snesBusPkg;

  // wram data port and its address counter
  localparam logic [`SNOOP_PA_W-1:0] wmData  = 8'h80;
  localparam logic [`SNOOP_PA_W-1:0] wmAddL  = 8'h81;
  localparam logic [`SNOOP_PA_W-1:0] wmAddM  = 8'h82;
  localparam logic [`SNOOP_PA_W-1:0] wmAddH  = 8'h83;

  // vram control, address and data
  localparam logic [`SNOOP_PA_W-1:0] vmain   = 8'h15;
  localparam logic [`SNOOP_PA_W-1:0] vmAddL  = 8'h16;
  localparam logic [`SNOOP_PA_W-1:0] vmAddH  = 8'h17;
  localparam logic [`SNOOP_PA_W-1:0] vmDataL = 8'h18;
  localparam logic [`SNOOP_PA_W-1:0] vmDataH = 8'h19;
  localparam logic [`SNOOP_PA_W-1:0] rdVramL = 8'h39;
  localparam logic [`SNOOP_PA_W-1:0] rdVramH = 8'h3A;

  // palette and sprite tables
  localparam logic [`SNOOP_PA_W-1:0] cgAdd   = 8'h21;
  localparam logic [`SNOOP_PA_W-1:0] cgData  = 8'h22;
  localparam logic [`SNOOP_PA_W-1:0] rdCgram = 8'h3B;
  localparam logic [`SNOOP_PA_W-1:0] oamAddL = 8'h02;
  localparam logic [`SNOOP_PA_W-1:0] oamAddH = 8'h03;
  localparam logic [`SNOOP_PA_W-1:0] oamData = 8'h04;
  localparam logic [`SNOOP_PA_W-1:0] rdOam   = 8'h38;

  // banks $7E and $7F share the top 7 address bits
  localparam logic [6:0] wramBank = 7'h3F;

endpackage

// File: design/snoopCfg.svh
`ifndef SNOOP_CFG_SVH
`define SNOOP_CFG_SVH

// ------------------------------------------------------------
// bus widths
// ------------------------------------------------------------

// cpu side A-bus address
`define SNOOP_ADDR_W 24

// ppu side B-bus peripheral address
`define SNOOP_PA_W 8

// both buses carry one byte
`define SNOOP_DATA_W 8

// shadow memory byte address
`define SNOOP_SHADOW_W 24

`endif

// File: design/snoopTop.sv
`timescale 1ns/10ps
`include "snoopCfg.svh"

module snoopTop (
  input  logic                       clkin,
  input  logic                       reset,
  input  logic [`SNOOP_ADDR_W-1:0]   snesAddr,
  input  logic [`SNOOP_PA_W-1:0]     snesPa,
  input  logic [`SNOOP_DATA_W-1:0]   snesDataIn,
  input  logic                       rdEnd,
  input  logic                       wrEnd,
  input  logic                       pardEnd,
  input  logic                       pawrEnd,
  input  logic                       wbAck,
  output logic                       wbCyc,
  output logic                       wbStb,
  output logic [`SNOOP_SHADOW_W-1:0] wbAdr,
  output logic [`SNOOP_DATA_W-1:0]   wbDatO,
  output logic                       dropped
);

  // ------------------------------------------------------------
  // sampled bus
  // ------------------------------------------------------------
  logic [`SNOOP_ADDR_W-1:0] sAddr;
  logic [`SNOOP_PA_W-1:0]   sPa;
  logic [`SNOOP_DATA_W-1:0] sData;
  logic                     sWr;
  logic                     sPard;
  logic                     sPawr;

  logic        wramHit;
  logic [16:0] wramOffset;
  logic        vramHit;
  logic [15:0] vramOffset;
  logic        cgramHit;
  logic [8:0]  cgramOffset;
  logic        oamHit;
  logic [9:0]  oamOffset;

  // cpu reads move no counter here
  busSampler sampler (
    .clkin, .reset, .snesAddr, .snesPa, .snesDataIn,
    .rdEnd, .wrEnd, .pardEnd, .pawrEnd,
    .sAddr, .sPa, .sData, .sRd(), .sWr, .sPard, .sPawr
  );

  wramTracker wram (
    .clkin, .reset, .sAddr, .sPa, .sData, .sWr, .sPard, .sPawr,
    .wramHit, .wramOffset
  );

  vramTracker vram (
    .clkin, .reset, .sPa, .sData, .sPard, .sPawr,
    .vramHit, .vramOffset
  );

  cgramOamTracker cgramOam (
    .clkin, .reset, .sPa, .sData, .sPard, .sPawr,
    .cgramHit, .cgramOffset, .oamHit, .oamOffset
  );

  writeCapture capture (
    .clkin, .reset, .sData,
    .wramHit, .wramOffset, .vramHit, .vramOffset,
    .cgramHit, .cgramOffset, .oamHit, .oamOffset,
    .wbAck, .wbCyc, .wbStb, .wbAdr, .wbDatO, .dropped
  );

endmodule

// File: design/vramTracker.sv
`timescale 1ns/10ps
`include "snoopCfg.svh"

module vramTracker (
  input  logic                     clkin,
  input  logic                     reset,
  input  logic [`SNOOP_PA_W-1:0]   sPa,
  input  logic [`SNOOP_DATA_W-1:0] sData,
  input  logic                     sPard,
  input  logic                     sPawr,
  output logic                     vramHit,
  output logic [15:0]              vramOffset
);

  logic [7:0]  vramCtrl;
  logic [15:0] wordAddr;
  logic [15:0] step;
  logic        lowAccess;
  logic        highAccess;
  logic        advance;
  logic [14:0] remapped;

  // bit 7 picks which half moves the address
  assign lowAccess  = (sPawr && sPa == snesBusPkg::vmDataL) ||
                      (sPard && sPa == snesBusPkg::rdVramL);
  assign highAccess = (sPawr && sPa == snesBusPkg::vmDataH) ||
                      (sPard && sPa == snesBusPkg::rdVramH);
  assign advance    = vramCtrl[7] ? highAccess : lowAccess;

  always_comb begin
    case (vramCtrl[1:0])
      2'd0:    step = 16'd1;
      2'd1:    step = 16'd32;
      default: step = 16'd128;
    endcase
  end

  // ------------------------------------------------------------
  // control byte and word address
  // ------------------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      vramCtrl <= '0;
      wordAddr <= '0;
    end else if (sPawr && sPa == snesBusPkg::vmain) begin
      vramCtrl <= sData;
    end else if (sPawr && sPa == snesBusPkg::vmAddL) begin
      wordAddr[7:0] <= sData;
    end else if (sPawr && sPa == snesBusPkg::vmAddH) begin
      wordAddr[15:8] <= sData;
    end else if (advance) begin
      wordAddr <= wordAddr + step;
    end
  end

  // address translation, low bits rotated left by 3
  always_comb begin
    case (vramCtrl[3:2])
      2'd0: remapped = wordAddr[14:0];
      2'd1: remapped = {wordAddr[14:8], wordAddr[4:0], wordAddr[7:5]};
      2'd2: remapped = {wordAddr[14:9], wordAddr[5:0], wordAddr[8:6]};
      default: remapped = {wordAddr[14:10], wordAddr[6:0], wordAddr[9:7]};
    endcase
  end

  assign vramHit    = sPawr && (sPa == snesBusPkg::vmDataL || sPa == snesBusPkg::vmDataH);
  assign vramOffset = {remapped, sPa[0]};

endmodule

// File: design/wramTracker.sv
`timescale 1ns/10ps
`include "snoopCfg.svh"

module wramTracker (
  input  logic                     clkin,
  input  logic                     reset,
  input  logic [`SNOOP_ADDR_W-1:0] sAddr,
  input  logic [`SNOOP_PA_W-1:0]   sPa,
  input  logic [`SNOOP_DATA_W-1:0] sData,
  input  logic                     sWr,
  input  logic                     sPard,
  input  logic                     sPawr,
  output logic                     wramHit,
  output logic [16:0]              wramOffset
);

  logic [16:0] portAddr;
  logic        mirrorHit;
  logic        bankHit;
  logic        portHit;

  // ------------------------------------------------------------
  // $2180 port address counter
  // ------------------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      portAddr <= '0;
    end else if (sPawr && sPa == snesBusPkg::wmAddL) begin
      portAddr[7:0] <= sData;
    end else if (sPawr && sPa == snesBusPkg::wmAddM) begin
      portAddr[15:8] <= sData;
    end else if (sPawr && sPa == snesBusPkg::wmAddH) begin
      // only one bank bit is real
      portAddr[16] <= sData[0];
    end else if ((sPawr || sPard) && sPa == snesBusPkg::wmData) begin
      portAddr <= portAddr + 17'd1;
    end
  end

  // ------------------------------------------------------------
  // capture decode
  // ------------------------------------------------------------

  // low 8K mirrored into banks $00-$3F and $80-$BF
  assign mirrorHit = sWr && !sAddr[22] && (sAddr[15:13] == 3'd0);
  assign bankHit   = sWr && (sAddr[`SNOOP_ADDR_W-1:17] == snesBusPkg::wramBank);
  assign portHit   = sPawr && (sPa == snesBusPkg::wmData);

  assign wramHit = mirrorHit || bankHit || portHit;

  always_comb begin
    if (mirrorHit) begin
      wramOffset = {4'd0, sAddr[12:0]};
    end else if (bankHit) begin
      wramOffset = sAddr[16:0];
    end else begin
      wramOffset = portAddr;
    end
  end

endmodule

// File: design/writeCapture.sv
`timescale 1ns/10ps
`include "snoopCfg.svh"

module writeCapture (
  input  logic                       clkin,
  input  logic                       reset,
  input  logic [`SNOOP_DATA_W-1:0]   sData,
  input  logic                       wramHit,
  input  logic [16:0]                wramOffset,
  input  logic                       vramHit,
  input  logic [15:0]                vramOffset,
  input  logic                       cgramHit,
  input  logic [8:0]                 cgramOffset,
  input  logic                       oamHit,
  input  logic [9:0]                 oamOffset,
  input  logic                       wbAck,
  output logic                       wbCyc,
  output logic                       wbStb,
  output logic [`SNOOP_SHADOW_W-1:0] wbAdr,
  output logic [`SNOOP_DATA_W-1:0]   wbDatO,
  output logic                       dropped
);

  logic [`SNOOP_SHADOW_W-1:0] regionBase;
  logic [`SNOOP_SHADOW_W-1:0] regionOffset;
  logic                       anyHit;
  logic                       accept;
  logic                       pending;

  // regions are disjoint, order only picks a default
  always_comb begin
    anyHit       = 1'b1;
    regionBase   = shadowMapPkg::wramBase;
    regionOffset = {{(`SNOOP_SHADOW_W - 17){1'b0}}, wramOffset};
    if (vramHit) begin
      regionBase   = shadowMapPkg::vramBase;
      regionOffset = {{(`SNOOP_SHADOW_W - 16){1'b0}}, vramOffset};
    end else if (cgramHit) begin
      regionBase   = shadowMapPkg::cgramBase;
      regionOffset = {{(`SNOOP_SHADOW_W - 9){1'b0}}, cgramOffset};
    end else if (oamHit) begin
      regionBase   = shadowMapPkg::oamBase;
      regionOffset = {{(`SNOOP_SHADOW_W - 10){1'b0}}, oamOffset};
    end else if (!wramHit) begin
      anyHit = 1'b0;
    end
  end

  assign accept = anyHit && !pending;

  // ------------------------------------------------------------
  // wishbone write, one slot deep
  // ------------------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      pending <= 1'b0;
      dropped <= 1'b0;
    end else if (pending) begin
      if (wbAck) pending <= 1'b0;
      // slot busy, this capture is lost
      if (anyHit) dropped <= 1'b1;
    end else if (anyHit) begin
      pending <= 1'b1;
    end
  end

  always_ff @(posedge clkin) begin
    if (accept) begin
      wbAdr  <= regionBase + regionOffset;
      wbDatO <= sData;
    end
  end

  assign wbCyc = pending;
  assign wbStb = pending;

endmodule

// File: dv/snoopChecker.sv
`timescale 1ns/10ps
`include "snoopCfg.svh"

module snoopChecker (
  input  logic                       clkin,
  input  logic                       reset,
  input  logic                       wbCyc,
  input  logic                       wbStb,
  input  logic                       wbAck,
  input  logic [`SNOOP_SHADOW_W-1:0] wbAdr,
  input  logic [`SNOOP_DATA_W-1:0]   wbDatO,
  input  logic                       dropped,
  input  logic                       rowStart,
  input  logic                       rowEnd,
  input  int                         rowNum,
  input  logic                       expWrite,
  input  logic                       expStall,
  input  logic                       expDropped,
  input  logic [`SNOOP_SHADOW_W-1:0] expAdr,
  input  logic [`SNOOP_DATA_W-1:0]   expData,
  output int                         errorCount,
  output int                         writeCount
);

  // writes still owed by earlier rows in order
  logic [`SNOOP_SHADOW_W-1:0] adrQ[$];
  logic [`SNOOP_DATA_W-1:0]   dataQ[$];
  int                         rowQ[$];
  logic [`SNOOP_SHADOW_W-1:0] wantAdr;
  logic [`SNOOP_DATA_W-1:0]   wantData;
  int                         wantRow;
  int                         errBefore;
  int                         rowErrStart;

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
    errorCount++;
  endtask

  // ------------------------------------------------------------
  // one acked Wishbone write
  // ------------------------------------------------------------
  task automatic checkWrite();
    writeCount++;
    if (adrQ.size() == 0) begin
      $display("%0t: Wishbone write of %02h to %06h that no row expected",
               $time, wbDatO, wbAdr);
      errorCount++;
    end else begin
      wantAdr   = adrQ.pop_front();
      wantData  = dataQ.pop_front();
      wantRow   = rowQ.pop_front();
      errBefore = errorCount;
      if (wbAdr !== wantAdr) reportMismatch("wbAdr", 32'(wantAdr), 32'(wbAdr));
      if (wbDatO !== wantData) reportMismatch("wbDatO", 32'(wantData), 32'(wbDatO));
      $display("row %0d: write %02h to %06h %s", wantRow, wbDatO, wbAdr,
               (errorCount == errBefore) ? "ok" : "failed");
    end
  endtask

  task automatic closeRow();
    if (dropped !== expDropped) begin
      reportMismatch("dropped", 32'(expDropped), 32'(dropped));
    end
    // a stalled row's write lands during the next row
    if (!expStall) begin
      while (adrQ.size() > 0) begin
        $display("row %0d: expected write to %06h never completed", rowQ[0], adrQ[0]);
        errorCount++;
        adrQ.delete(0);
        dataQ.delete(0);
        rowQ.delete(0);
      end
    end
    if (!expWrite) begin
      $display("row %0d: no write %s", rowNum, (errorCount == rowErrStart) ? "ok" : "failed");
    end
  endtask

  always @(posedge clkin) begin
    if (reset) begin
      errorCount = 0;
      writeCount = 0;
      adrQ.delete();
      dataQ.delete();
      rowQ.delete();
    end else begin
      // strobe and cycle rise and fall together
      if (wbStb !== wbCyc) reportMismatch("wbStb", 32'(wbCyc), 32'(wbStb));
      if (wbCyc && wbStb && wbAck) checkWrite();
      if (rowEnd) closeRow();
      if (rowStart) begin
        rowErrStart = errorCount;
        if (expWrite) begin
          adrQ.push_back(expAdr);
          dataQ.push_back(expData);
          rowQ.push_back(rowNum);
        end
      end
    end
  end

endmodule

// File: dv/snoopTb.sv
`timescale 1ns/10ps
`include "snoopCfg.svh"

module snoopTb;

  localparam logic [1:0] cpuWrite = 2'd0;
  localparam logic [1:0] cpuRead  = 2'd1;
  localparam logic [1:0] busWrite = 2'd2;
  localparam logic [1:0] busRead  = 2'd3;

  logic                       clkin;
  logic                       reset;
  logic [`SNOOP_ADDR_W-1:0]   snesAddr;
  logic [`SNOOP_PA_W-1:0]     snesPa;
  logic [`SNOOP_DATA_W-1:0]   snesDataIn;
  logic                       rdEnd;
  logic                       wrEnd;
  logic                       pardEnd;
  logic                       pawrEnd;
  logic                       wbAck;
  logic                       wbCyc;
  logic                       wbStb;
  logic [`SNOOP_SHADOW_W-1:0] wbAdr;
  logic [`SNOOP_DATA_W-1:0]   wbDatO;
  logic                       dropped;

  // current row for the checker
  logic                       rowStart;
  logic                       rowEnd;
  logic                       holdAck;
  int                         rowNum;
  logic                       expWrite;
  logic                       expStall;
  logic                       expDropped;
  logic [`SNOOP_SHADOW_W-1:0] expAdr;
  logic [`SNOOP_DATA_W-1:0]   expData;
  int                         errorCount;
  int                         writeCount;
  int                         ackDelay;
  int unsigned                seedValue;

  // stimulus table with one entry per row
  logic [1:0]  kindTab[$];
  logic [23:0] addrTab[$];
  logic [7:0]  dataTab[$];
  logic        stallTab[$];
  logic        writeTab[$];
  logic [23:0] adrTab[$];
  logic [7:0]  wdataTab[$];
  logic        dropTab[$];

  tbClock clockGen (.clkin, .reset);

  snoopTop DUT (
    .clkin, .reset, .snesAddr, .snesPa, .snesDataIn,
    .rdEnd, .wrEnd, .pardEnd, .pawrEnd,
    .wbAck, .wbCyc, .wbStb, .wbAdr, .wbDatO, .dropped
  );

  snoopChecker wbCheck (
    .clkin, .reset, .wbCyc, .wbStb, .wbAck, .wbAdr, .wbDatO, .dropped,
    .rowStart, .rowEnd, .rowNum, .expWrite, .expStall, .expDropped,
    .expAdr, .expData, .errorCount, .writeCount
  );

  task automatic addRow(input logic [1:0] kind, input logic [23:0] addr,
                        input logic [7:0] data, input logic stall, input logic hasWrite,
                        input logic [23:0] adr, input logic [7:0] wdata, input logic drop);
    kindTab.push_back(kind);
    addrTab.push_back(addr);
    dataTab.push_back(data);
    stallTab.push_back(stall);
    writeTab.push_back(hasWrite);
    adrTab.push_back(adr);
    wdataTab.push_back(wdata);
    dropTab.push_back(drop);
  endtask

  // ------------------------------------------------------------
  // kind, address, data, stall, write?, shadow address, data, dropped
  // ------------------------------------------------------------
  task automatic fillTable();
    // wram mirror then bank $7F where the bank bit is offset bit 16
    addRow(cpuWrite, 24'h000123, 8'hA5, 1'b0, 1'b1, 24'hF50123, 8'hA5, 1'b0);
    addRow(cpuWrite, 24'h7F2345, 8'h3C, 1'b0, 1'b1, 24'hF62345, 8'h3C, 1'b0);
    addRow(busWrite, 24'h000081, 8'h10, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000082, 8'h00, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000083, 8'h01, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000080, 8'h11, 1'b0, 1'b1, 24'hF60010, 8'h11, 1'b0);
    addRow(busWrite, 24'h000080, 8'h22, 1'b0, 1'b1, 24'hF60011, 8'h22, 1'b0);
    // vram word $1234 where the high half steps the address
    addRow(busWrite, 24'h000015, 8'h80, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000016, 8'h34, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000017, 8'h12, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000018, 8'h01, 1'b0, 1'b1, 24'hF72468, 8'h01, 1'b0);
    addRow(busWrite, 24'h000019, 8'h02, 1'b0, 1'b1, 24'hF72469, 8'h02, 1'b0);
    addRow(busWrite, 24'h000018, 8'h03, 1'b0, 1'b1, 24'hF7246A, 8'h03, 1'b0);
    // step 32 and a $213A read that only moves the address
    addRow(busWrite, 24'h000015, 8'h81, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000019, 8'h04, 1'b0, 1'b1, 24'hF7246B, 8'h04, 1'b0);
    addRow(busWrite, 24'h000019, 8'h05, 1'b0, 1'b1, 24'hF724AB, 8'h05, 1'b0);
    addRow(busRead,  24'h00003A, 8'h00, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000019, 8'h06, 1'b0, 1'b1, 24'hF7252B, 8'h06, 1'b0);
    // remap mode 1 rotates word $0023 to $0019
    addRow(busWrite, 24'h000015, 8'h84, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000016, 8'h23, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000017, 8'h00, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000018, 8'h07, 1'b0, 1'b1, 24'hF70032, 8'h07, 1'b0);
    // low half steps the address when bit 7 is clear
    addRow(busWrite, 24'h000015, 8'h00, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000018, 8'h0C, 1'b0, 1'b1, 24'hF70046, 8'h0C, 1'b0);
    addRow(busWrite, 24'h000018, 8'h0D, 1'b0, 1'b1, 24'hF70048, 8'h0D, 1'b0);
    // palette
    addRow(busWrite, 24'h000021, 8'h10, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000022, 8'h08, 1'b0, 1'b1, 24'hF90020, 8'h08, 1'b0);
    addRow(busRead,  24'h00003B, 8'h00, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000022, 8'h09, 1'b0, 1'b1, 24'hF90022, 8'h09, 1'b0);
    // sprite high table
    addRow(busWrite, 24'h000002, 8'h05, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000003, 8'h01, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000004, 8'h0A, 1'b0, 1'b1, 24'hF9040A, 8'h0A, 1'b0);
    // bit 9 stays set and address bits 8:5 fold away
    addRow(busWrite, 24'h000002, 8'h15, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(busWrite, 24'h000004, 8'h0B, 1'b0, 1'b1, 24'hF9040A, 8'h0B, 1'b0);
    // accesses that capture nothing
    addRow(busWrite, 24'h000000, 8'h0F, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(cpuWrite, 24'h400000, 8'h11, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    addRow(cpuRead,  24'h000123, 8'h00, 1'b0, 1'b0, 24'h0, 8'h00, 1'b0);
    // second capture is lost under back-pressure
    addRow(cpuWrite, 24'h000200, 8'h5A, 1'b1, 1'b1, 24'hF50200, 8'h5A, 1'b0);
    addRow(cpuWrite, 24'h000201, 8'h5B, 1'b0, 1'b0, 24'h0, 8'h00, 1'b1);
    addRow(cpuWrite, 24'h7E0001, 8'h77, 1'b0, 1'b1, 24'hF50001, 8'h77, 1'b1);
    addRow(busWrite, 24'h000000, 8'h00, 1'b0, 1'b0, 24'h0, 8'h00, 1'b1);
  endtask

  // one access and the gap to the next row
  task automatic applyRow(input int i);
    rowNum     <= i;
    expWrite   <= writeTab[i];
    expStall   <= stallTab[i];
    expDropped <= dropTab[i];
    expAdr     <= adrTab[i];
    expData    <= wdataTab[i];
    rowStart   <= 1'b1;
    if (stallTab[i]) holdAck <= 1'b1;
    snesAddr   <= addrTab[i];
    snesPa     <= addrTab[i][7:0];
    snesDataIn <= dataTab[i];
    wrEnd      <= (kindTab[i] == cpuWrite);
    rdEnd      <= (kindTab[i] == cpuRead);
    pawrEnd    <= (kindTab[i] == busWrite);
    pardEnd    <= (kindTab[i] == busRead);
    @(posedge clkin);
    rowStart <= 1'b0;
    wrEnd    <= 1'b0;
    rdEnd    <= 1'b0;
    pawrEnd  <= 1'b0;
    pardEnd  <= 1'b0;
    if (!stallTab[i]) holdAck <= 1'b0;
    repeat (stallTab[i] ? 0 : 8) @(posedge clkin);
    rowEnd <= 1'b1;
    @(posedge clkin);
    rowEnd <= 1'b0;
  endtask

  initial begin
    snesAddr   = '0;
    snesPa     = '0;
    snesDataIn = '0;
    rdEnd      = 1'b0;
    wrEnd      = 1'b0;
    pardEnd    = 1'b0;
    pawrEnd    = 1'b0;
    rowStart   = 1'b0;
    rowEnd     = 1'b0;
    holdAck    = 1'b0;
    rowNum     = 0;
    expWrite   = 1'b0;
    expStall   = 1'b0;
    expDropped = 1'b0;
    expAdr     = '0;
    expData    = '0;
    fillTable();
    @(negedge reset);
    @(posedge clkin);
    for (int i = 0; i < kindTab.size(); i++) begin
      applyRow(i);
    end
    repeat (4) @(posedge clkin);
    $display("%0d rows, %0d writes, %0d errors", kindTab.size(), writeCount, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // ------------------------------------------------------------
  // shadow memory slave acks after 0 to 3 cycles
  // ------------------------------------------------------------
  initial begin
    wbAck     = 1'b0;
    seedValue = $urandom(32'hfd4f3688);
    forever begin
      @(posedge clkin);
      if (wbCyc && wbStb) begin
        ackDelay = $urandom % 4;
        repeat (ackDelay) @(posedge clkin);
        while (holdAck) @(posedge clkin);
        wbAck <= 1'b1;
        @(posedge clkin);
        wbAck <= 1'b0;
      end
    end
  end

  // watchdog
  initial begin
    @(negedge reset);
    repeat (kindTab.size() * 20 + 100) @(posedge clkin);
    $display("watchdog: the rows did not finish in time");
    $display("Something failed");
    $finish;
  end

endmodule

// File: dv/tbClock.sv
`timescale 1ns/10ps

module tbClock (
  output logic clkin,
  output logic reset
);

  // 10 ns period
  initial begin
    clkin = 1'b0;
    forever #5 clkin = ~clkin;
  end

  // reset held for the first 3 rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clkin);
    reset <= 1'b0;
  end

endmodule

// File: files.f
+incdir+design
design/snesBusPkg.sv
design/shadowMapPkg.sv
design/busSampler.sv
design/wramTracker.sv
design/vramTracker.sv
design/cgramOamTracker.sv
design/writeCapture.sv
design/snoopTop.sv
dv/tbClock.sv
dv/snoopChecker.sv
dv/snoopTb.sv
